/* run_sim.sh */
#!/bin/bash
# compile the testbench with verilator, run it, then look for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module tb_tmu \
	-f tmu.f -o sim_tmu || exit 1
./obj_dir/sim_tmu > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/tmu_addr.sv */
module tmu_addr (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  tmu_pkg::tmu_cfg_t             cfg,
	input  tmu_pkg::scan_beat_t           beat_in,

	output logic                          tex_rd_en,
	output logic [tmu_pkg::adr_w-1:0]     tex_rd_adr,
	output logic                          fb_rd_en,
	output logic [tmu_pkg::adr_w-1:0]     fb_rd_adr,

	output tmu_pkg::fetch_beat_t          beat_out
);

	logic [21:0]               tex_line;
	logic [21:0]               dst_line;
	logic [tmu_pkg::adr_w-1:0] tex_col;
	logic [tmu_pkg::adr_w-1:0] dst_col;
	logic [tmu_pkg::adr_w-1:0] tex_adr;
	logic [tmu_pkg::adr_w-1:0] dst_adr;

	// row start offsets, 11 by 11 bits
	assign tex_line = beat_in.tex_y * cfg.tex_hres;
	assign dst_line = beat_in.dst_y * cfg.dst_hres;

	assign tex_col = beat_in.tex_x;
	assign dst_col = beat_in.dst_x;

	// both wrap at adr_w bits
	assign tex_adr = cfg.tex_fbuf + tex_line[tmu_pkg::adr_w-1:0] + tex_col;
	assign dst_adr = cfg.dst_fbuf + dst_line[tmu_pkg::adr_w-1:0] + dst_col;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tex_rd_en <= 1'b0;
			fb_rd_en <= 1'b0;
			beat_out.valid <= 1'b0;
			beat_out.last <= 1'b0;
		end else begin
			tex_rd_en <= beat_in.valid;
			// the old pixel is only needed for mixing
			fb_rd_en <= beat_in.valid && (cfg.alpha != tmu_pkg::alpha_opaque);
			beat_out.valid <= beat_in.valid;
			beat_out.last <= beat_in.last;
		end
	end

	always_ff @(posedge sys_clk) begin
		tex_rd_adr <= tex_adr;
		fb_rd_adr <= dst_adr;
		beat_out.dst_adr <= dst_adr;
	end

endmodule

/* source/tmu_blend.sv */
module tmu_blend (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  tmu_pkg::tmu_cfg_t             cfg,
	input  tmu_pkg::fetch_beat_t          beat_in,
	input  tmu_pkg::pixel_t               tex_rd_data,
	input  tmu_pkg::pixel_t               fb_rd_data,

	output logic                          fb_we,
	output logic [tmu_pkg::adr_w-1:0]     fb_wr_adr,
	output tmu_pkg::pixel_t               fb_wr_data
);

	logic       valid_q;
	logic       keyed;
	logic       opaque;
	logic [6:0] bright_w;
	logic [6:0] src_w;
	logic [6:0] dst_w;
	logic [5:0] bc_r;
	logic [5:0] bc_g;
	logic [5:0] bc_b;
	logic [5:0] mix_r;
	logic [5:0] mix_g;
	logic [5:0] mix_b;

	// weighted sum of two channels over 64
	function automatic logic [5:0] mix(
		input logic [5:0] c,
		input logic [5:0] d,
		input logic [6:0] wc,
		input logic [6:0] wd
	);
		logic [12:0] acc;
		acc = c * wc + d * wd;
		return acc[11:6];
	endfunction

	// ==================================================
	// write stage, data arrives with the registered beat
	// ==================================================
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid_q <= 1'b0;
		else
			valid_q <= beat_in.valid;
	end

	always_ff @(posedge sys_clk) begin
		fb_wr_adr <= beat_in.dst_adr;
	end

	assign keyed = cfg.chroma_key_en && (tex_rd_data.raw == cfg.chroma_key);
	assign fb_we = valid_q && !keyed;

	assign opaque = cfg.alpha == tmu_pkg::alpha_opaque;
	assign bright_w = {1'b0, cfg.brightness} + 7'd1;
	assign src_w = {1'b0, cfg.alpha} + 7'd1;
	assign dst_w = {1'b0, tmu_pkg::alpha_opaque - cfg.alpha};

	// brightness first, five bit channels zero extended
	assign bc_r = mix({1'b0, tex_rd_data.rgb.r}, 6'd0, bright_w, 7'd0);
	assign bc_g = mix(tex_rd_data.rgb.g, 6'd0, bright_w, 7'd0);
	assign bc_b = mix({1'b0, tex_rd_data.rgb.b}, 6'd0, bright_w, 7'd0);

	// then alpha against the old framebuffer pixel
	assign mix_r = mix(bc_r, {1'b0, fb_rd_data.rgb.r}, src_w, dst_w);
	assign mix_g = mix(bc_g, fb_rd_data.rgb.g, src_w, dst_w);
	assign mix_b = mix(bc_b, {1'b0, fb_rd_data.rgb.b}, src_w, dst_w);

	always_comb begin
		if (opaque) begin
			fb_wr_data.rgb.r = bc_r[4:0];
			fb_wr_data.rgb.g = bc_g;
			fb_wr_data.rgb.b = bc_b[4:0];
		end else begin
			fb_wr_data.rgb.r = mix_r[4:0];
			fb_wr_data.rgb.g = mix_g;
			fb_wr_data.rgb.b = mix_b[4:0];
		end
	end

endmodule

/* source/tmu_ctlif.sv */
module tmu_ctlif (
	input  logic                sys_clk,
	input  logic                sys_rst,

	input  logic [13:0]         csr_a,
	input  logic                csr_we,
	input  logic [31:0]         csr_di,
	output logic [31:0]         csr_do,

	input  logic                busy,
	output logic                start,
	output logic                irq,
	output tmu_pkg::tmu_cfg_t   cfg
);

	logic        csr_hit;
	logic [4:0]  idx;
	logic [31:0] rd_data;
	logic        busy_q;

	assign csr_hit = csr_a[13:10] == tmu_pkg::csr_sel;
	assign idx = csr_a[4:0];

	// ==================================================
	// register writes and run control
	// ==================================================
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg <= tmu_pkg::cfg_default;
			start <= 1'b0;
			irq <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= busy;
			// end of run seen as busy going low
			irq <= busy_q & ~busy;
			start <= 1'b0;
			if (csr_hit && csr_we) begin
				case (idx)
					tmu_pkg::reg_ctl: begin
						// a start while a run is going, or just launched, is dropped
						start <= csr_di[0] & ~busy & ~start;
						cfg.chroma_key_en <= csr_di[1];
					end
					tmu_pkg::reg_brightness:  cfg.brightness <= csr_di[5:0];
					tmu_pkg::reg_chroma_key:  cfg.chroma_key <= csr_di[15:0];
					tmu_pkg::reg_tex_fbuf:    cfg.tex_fbuf <= csr_di[tmu_pkg::adr_w-1:0];
					tmu_pkg::reg_tex_hres:    cfg.tex_hres <= csr_di[10:0];
					tmu_pkg::reg_tex_hmask:   cfg.tex_hmask <= csr_di[10:0];
					tmu_pkg::reg_tex_vmask:   cfg.tex_vmask <= csr_di[10:0];
					tmu_pkg::reg_dst_fbuf:    cfg.dst_fbuf <= csr_di[tmu_pkg::adr_w-1:0];
					tmu_pkg::reg_dst_hres:    cfg.dst_hres <= csr_di[10:0];
					tmu_pkg::reg_dst_vres:    cfg.dst_vres <= csr_di[10:0];
					tmu_pkg::reg_dst_hoffset: cfg.dst_hoffset <= csr_di[11:0];
					tmu_pkg::reg_dst_voffset: cfg.dst_voffset <= csr_di[11:0];
					tmu_pkg::reg_dst_squarew: cfg.dst_squarew <= csr_di[10:0];
					tmu_pkg::reg_dst_squareh: cfg.dst_squareh <= csr_di[10:0];
					tmu_pkg::reg_alpha:       cfg.alpha <= csr_di[5:0];
					default: ;
				endcase
			end
		end
	end

	// ==================================================
	// readback
	// ==================================================
	always_comb begin
		rd_data = 32'd0;
		case (idx)
			tmu_pkg::reg_ctl:         rd_data = {30'd0, cfg.chroma_key_en, busy};
			tmu_pkg::reg_brightness:  rd_data = {26'd0, cfg.brightness};
			tmu_pkg::reg_chroma_key:  rd_data = {16'd0, cfg.chroma_key};
			tmu_pkg::reg_tex_fbuf:    rd_data = {12'd0, cfg.tex_fbuf};
			tmu_pkg::reg_tex_hres:    rd_data = {21'd0, cfg.tex_hres};
			tmu_pkg::reg_tex_hmask:   rd_data = {21'd0, cfg.tex_hmask};
			tmu_pkg::reg_tex_vmask:   rd_data = {21'd0, cfg.tex_vmask};
			tmu_pkg::reg_dst_fbuf:    rd_data = {12'd0, cfg.dst_fbuf};
			tmu_pkg::reg_dst_hres:    rd_data = {21'd0, cfg.dst_hres};
			tmu_pkg::reg_dst_vres:    rd_data = {21'd0, cfg.dst_vres};
			// offsets come back sign extended
			tmu_pkg::reg_dst_hoffset: rd_data = {{20{cfg.dst_hoffset[11]}}, cfg.dst_hoffset};
			tmu_pkg::reg_dst_voffset: rd_data = {{20{cfg.dst_voffset[11]}}, cfg.dst_voffset};
			tmu_pkg::reg_dst_squarew: rd_data = {21'd0, cfg.dst_squarew};
			tmu_pkg::reg_dst_squareh: rd_data = {21'd0, cfg.dst_squareh};
			tmu_pkg::reg_alpha:       rd_data = {26'd0, cfg.alpha};
			default:                  rd_data = 32'd0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= 32'd0;
		end else begin
			csr_do <= csr_hit ? rd_data : 32'd0;
		end
	end

endmodule

/* source/tmu_pkg.sv */
package tmu_pkg;

	// ==================================================
	// widths and csr map
	// ==================================================

	// pixel address width, one word per pixel
	localparam int adr_w = 20;

	// csr_a[13:10] value that selects this unit
	localparam logic [3:0] csr_sel = 4'h2;

	localparam logic [4:0] reg_ctl         = 5'd0;
	localparam logic [4:0] reg_brightness  = 5'd1;
	localparam logic [4:0] reg_chroma_key  = 5'd2;
	localparam logic [4:0] reg_tex_fbuf    = 5'd3;
	localparam logic [4:0] reg_tex_hres    = 5'd4;
	localparam logic [4:0] reg_tex_hmask   = 5'd5;
	localparam logic [4:0] reg_tex_vmask   = 5'd6;
	localparam logic [4:0] reg_dst_fbuf    = 5'd7;
	localparam logic [4:0] reg_dst_hres    = 5'd8;
	localparam logic [4:0] reg_dst_vres    = 5'd9;
	localparam logic [4:0] reg_dst_hoffset = 5'd10;
	localparam logic [4:0] reg_dst_voffset = 5'd11;
	localparam logic [4:0] reg_dst_squarew = 5'd12;
	localparam logic [4:0] reg_dst_squareh = 5'd13;
	localparam logic [4:0] reg_alpha       = 5'd14;

	// alpha at this value means no framebuffer read and no mixing
	localparam logic [5:0] alpha_opaque = 6'd63;

	// ==================================================
	// types
	// ==================================================

	// same 16 bits, compared raw for the key, split for blending
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
	} pixel_t;

	typedef struct packed {
		logic              chroma_key_en;
		logic [5:0]        brightness;
		logic [15:0]       chroma_key;
		logic [adr_w-1:0]  tex_fbuf;
		logic [10:0]       tex_hres;
		logic [10:0]       tex_hmask;
		logic [10:0]       tex_vmask;
		logic [adr_w-1:0]  dst_fbuf;
		logic [10:0]       dst_hres;
		logic [10:0]       dst_vres;
		logic signed [11:0] dst_hoffset;
		logic signed [11:0] dst_voffset;
		logic [10:0]       dst_squarew;
		logic [10:0]       dst_squareh;
		logic [5:0]        alpha;
	} tmu_cfg_t;

	localparam tmu_cfg_t cfg_default = '{
		chroma_key_en: 1'b0,
		brightness:    6'd63,
		chroma_key:    16'd0,
		tex_fbuf:      '0,
		tex_hres:      11'd512,
		tex_hmask:     '1,
		tex_vmask:     '1,
		dst_fbuf:      '0,
		dst_hres:      11'd640,
		dst_vres:      11'd480,
		dst_hoffset:   12'sd0,
		dst_voffset:   12'sd0,
		dst_squarew:   11'd16,
		dst_squareh:   11'd16,
		alpha:         6'd63
	};

	// one square position from the scanner
	typedef struct packed {
		logic        valid;
		logic        last;
		logic [10:0] tex_x;
		logic [10:0] tex_y;
		logic [10:0] dst_x;
		logic [10:0] dst_y;
	} scan_beat_t;

	// pixel waiting for its read data
	typedef struct packed {
		logic             valid;
		logic             last;
		logic [adr_w-1:0] dst_adr;
	} fetch_beat_t;

endpackage

/* source/tmu_scan.sv */
module tmu_scan (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  start,
	input  tmu_pkg::tmu_cfg_t     cfg,
	output tmu_pkg::scan_beat_t   beat,
	output logic                  running
);

	logic [10:0]        col;
	logic [10:0]        row;
	logic               col_last;
	logic               row_last;
	logic signed [12:0] pos_x;
	logic signed [12:0] pos_y;
	logic               in_x;
	logic               in_y;

	assign col_last = col == cfg.dst_squarew - 11'd1;
	assign row_last = row == cfg.dst_squareh - 11'd1;

	// destination position, may fall outside the framebuffer
	assign pos_x = $signed(cfg.dst_hoffset) + $signed({2'b00, col});
	assign pos_y = $signed(cfg.dst_voffset) + $signed({2'b00, row});

	assign in_x = !pos_x[12] && (pos_x[11:0] < {1'b0, cfg.dst_hres});
	assign in_y = !pos_y[12] && (pos_y[11:0] < {1'b0, cfg.dst_vres});

	// ==================================================
	// square walk, row major
	// ==================================================
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			running <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (start) begin
			// an empty square never runs
			running <= (cfg.dst_squarew != '0) && (cfg.dst_squareh != '0);
			col <= '0;
			row <= '0;
		end else if (running) begin
			if (col_last) begin
				col <= '0;
				row <= row + 11'd1;
				if (row_last)
					running <= 1'b0;
			end else begin
				col <= col + 11'd1;
			end
		end
	end

	always_comb begin
		beat.valid = running && in_x && in_y;
		beat.last = running && col_last && row_last;
		beat.tex_x = col & cfg.tex_hmask;
		beat.tex_y = row & cfg.tex_vmask;
		// only meaningful when valid, then both lie in 0..2047
		beat.dst_x = pos_x[10:0];
		beat.dst_y = pos_y[10:0];
	end

endmodule

/* source/tmu_top.sv */
module tmu_top (
	input  logic                          sys_clk,
	input  logic                          sys_rst,

	input  logic [13:0]                   csr_a,
	input  logic                          csr_we,
	input  logic [31:0]                   csr_di,
	output logic [31:0]                   csr_do,
	output logic                          irq,

	output logic                          tex_rd_en,
	output logic [tmu_pkg::adr_w-1:0]     tex_rd_adr,
	input  tmu_pkg::pixel_t               tex_rd_data,

	output logic                          fb_rd_en,
	output logic [tmu_pkg::adr_w-1:0]     fb_rd_adr,
	input  tmu_pkg::pixel_t               fb_rd_data,

	output logic                          fb_we,
	output logic [tmu_pkg::adr_w-1:0]     fb_wr_adr,
	output tmu_pkg::pixel_t               fb_wr_data
);

	tmu_pkg::tmu_cfg_t    cfg;
	tmu_pkg::scan_beat_t  scan_beat;
	tmu_pkg::fetch_beat_t fetch_beat;
	logic                 start;
	logic                 running;
	logic                 addr_busy;
	logic                 blend_busy;
	logic                 busy;

	// ==================================================
	// run status
	// ==================================================
	// the addr stage also counts as busy while it holds the end marker
	assign addr_busy = fetch_beat.valid | fetch_beat.last;
	assign blend_busy = fb_we;
	assign busy = running | addr_busy | blend_busy;

	tmu_ctlif tmu_ctlif_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.busy    (busy),
		.start   (start),
		.irq     (irq),
		.cfg     (cfg)
	);

	tmu_scan tmu_scan_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.start   (start),
		.cfg     (cfg),
		.beat    (scan_beat),
		.running (running)
	);

	tmu_addr tmu_addr_inst (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.cfg        (cfg),
		.beat_in    (scan_beat),
		.tex_rd_en  (tex_rd_en),
		.tex_rd_adr (tex_rd_adr),
		.fb_rd_en   (fb_rd_en),
		.fb_rd_adr  (fb_rd_adr),
		.beat_out   (fetch_beat)
	);

	tmu_blend tmu_blend_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.cfg         (cfg),
		.beat_in     (fetch_beat),
		.tex_rd_data (tex_rd_data),
		.fb_rd_data  (fb_rd_data),
		.fb_we       (fb_we),
		.fb_wr_adr   (fb_wr_adr),
		.fb_wr_data  (fb_wr_data)
	);

endmodule

/* test/tb_tmu_model.svh */
`ifndef TB_TMU_MODEL_SVH
`define TB_TMU_MODEL_SVH

// ==================================================
// random numbers
// ==================================================

// 32 bit lcg, upper half folded into the low bits
function automatic logic [31:0] next_rand();
	seed = seed * 32'd1664525 + 32'd1013904223;
	return seed ^ (seed >> 16);
endfunction

// value a register reads back after data was written to it
function automatic logic [31:0] reg_readback(input logic [4:0] idx, input logic [31:0] data);
	case (idx)
		tmu_pkg::reg_ctl:
			return {30'd0, data[1], 1'b0};
		tmu_pkg::reg_brightness, tmu_pkg::reg_alpha:
			return {26'd0, data[5:0]};
		tmu_pkg::reg_chroma_key:
			return {16'd0, data[15:0]};
		tmu_pkg::reg_tex_fbuf, tmu_pkg::reg_dst_fbuf:
			return {12'd0, data[19:0]};
		// offsets are signed 12 bit
		tmu_pkg::reg_dst_hoffset, tmu_pkg::reg_dst_voffset:
			return {{20{data[11]}}, data[11:0]};
		tmu_pkg::reg_tex_hres, tmu_pkg::reg_tex_hmask, tmu_pkg::reg_tex_vmask,
		tmu_pkg::reg_dst_hres, tmu_pkg::reg_dst_vres,
		tmu_pkg::reg_dst_squarew, tmu_pkg::reg_dst_squareh:
			return {21'd0, data[10:0]};
		default:
			return 32'd0;
	endcase
endfunction

// ==================================================
// reference model of one run
// ==================================================

// one colour channel, brightness first, then mixed with the old pixel
function automatic int blend_channel(input int c, input int d, input int bri, input int alpha);
	int bc;
	bc = (c * (bri + 1)) >> 6;
	if (alpha == 63)
		return bc;
	return (bc * (alpha + 1) + d * (63 - alpha)) >> 6;
endfunction

// applies the configured square to exp_mem, which holds the old framebuffer
function automatic void model_run();
	int          row;
	int          col;
	int          x;
	int          y;
	int          bri;
	int          alpha;
	logic [19:0] tex_adr;
	logic [19:0] dst_adr;
	logic [15:0] t;
	logic [15:0] d;
	bri = int'(shadow[1]);
	alpha = int'(shadow[14]);
	for (row = 0; row < int'(shadow[13]); row++) begin
		for (col = 0; col < int'(shadow[12]); col++) begin
			x = int'(shadow[10]) + col;
			y = int'(shadow[11]) + row;
			// clipped positions are never written
			if (x < 0 || y < 0 || x >= int'(shadow[8]) || y >= int'(shadow[9]))
				continue;
			tex_adr = 20'(shadow[3] + (row & shadow[6]) * shadow[4] + (col & shadow[5]));
			dst_adr = 20'(shadow[7] + y * shadow[8] + x);
			t = tex_mem[tex_adr[11:0]];
			if (shadow[0][1] && t == shadow[2][15:0])
				continue;
			d = exp_mem[dst_adr[11:0]];
			exp_mem[dst_adr[11:0]] = {5'(blend_channel(t[15:11], d[15:11], bri, alpha)),
				6'(blend_channel(t[10:5], d[10:5], bri, alpha)),
				5'(blend_channel(t[4:0], d[4:0], bri, alpha))};
		end
	end
endfunction

`endif

/* test/tb_tmu.sv */
module tb_tmu;

	timeunit 1ns;
	timeprecision 100ps;

	// four squares of 16 by 16 plus csr traffic and a wide margin
	localparam int cycle_limit = 6000;
	localparam int mem_words = 4096;

	logic                      sys_clk;
	logic                      sys_rst;
	logic [13:0]               csr_a;
	logic                      csr_we;
	logic [31:0]               csr_di;
	logic [31:0]               csr_do;
	logic                      irq;
	logic                      tex_rd_en;
	logic [tmu_pkg::adr_w-1:0] tex_rd_adr;
	logic [15:0]               tex_rd_data;
	logic                      fb_rd_en;
	logic [tmu_pkg::adr_w-1:0] fb_rd_adr;
	logic [15:0]               fb_rd_data;
	logic                      fb_we;
	logic [tmu_pkg::adr_w-1:0] fb_wr_adr;
	logic [15:0]               fb_wr_data;

	logic [15:0] tex_mem [mem_words];
	logic [15:0] fb_mem [mem_words];
	logic [15:0] exp_mem [mem_words];
	// expected readback of every register
	logic [31:0] shadow [15];
	logic [31:0] seed;
	int          cycle_cnt;
	int          irq_count;
	int          irq_cycle;
	int          last_we_cycle;

	`include "tb_tmu_model.svh"

	tmu_top tmu_top_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr_a       (csr_a),
		.csr_we      (csr_we),
		.csr_di      (csr_di),
		.csr_do      (csr_do),
		.irq         (irq),
		.tex_rd_en   (tex_rd_en),
		.tex_rd_adr  (tex_rd_adr),
		.tex_rd_data (tex_rd_data),
		.fb_rd_en    (fb_rd_en),
		.fb_rd_adr   (fb_rd_adr),
		.fb_rd_data  (fb_rd_data),
		.fb_we       (fb_we),
		.fb_wr_adr   (fb_wr_adr),
		.fb_wr_data  (fb_wr_data)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// ==================================================
	// memories and run monitor
	// ==================================================
	always @(posedge sys_clk) begin
		if (tex_rd_en)
			tex_rd_data <= tex_mem[tex_rd_adr[11:0]];
		if (fb_rd_en)
			fb_rd_data <= fb_mem[fb_rd_adr[11:0]];
		if (fb_we)
			fb_mem[fb_wr_adr[11:0]] <= fb_wr_data;
	end

	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (fb_we)
			last_we_cycle = cycle_cnt;
		if (irq) begin
			irq_count = irq_count + 1;
			irq_cycle = cycle_cnt;
		end
		if (cycle_cnt >= cycle_limit) begin
			$display("Some tests failed");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", cycle_limit);
		end
	end

	// ==================================================
	// csr access and checks
	// ==================================================
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic write_csr(input logic [3:0] sel, input logic [4:0] idx,
		input logic [31:0] data);
		csr_a = {sel, 5'd0, idx};
		csr_di = data;
		csr_we = 1'b1;
		@(posedge sys_clk);
		#2;
		csr_we = 1'b0;
		if (sel == tmu_pkg::csr_sel && idx < 5'd15)
			shadow[idx] = reg_readback(idx, data);
	endtask

	// csr_do follows the address one cycle later
	task automatic expect_reg(input string name, input logic [3:0] sel, input logic [4:0] idx,
		input logic [31:0] expected);
		csr_a = {sel, 5'd0, idx};
		csr_we = 1'b0;
		@(posedge sys_clk);
		#2;
		check_value(name, expected, csr_do);
	endtask

	task automatic configure_run(input logic [31:0] bri, input logic [31:0] key,
		input logic [31:0] hmask, input logic [31:0] vmask, input logic [31:0] hoff,
		input logic [31:0] voff, input logic [31:0] alpha);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_brightness, bri);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_chroma_key, key);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_tex_fbuf, 32'h123);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_tex_hres, 32'd64);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_tex_hmask, hmask);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_tex_vmask, vmask);
		// 64 by 40 destination inside the framebuffer array
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_fbuf, 32'h2a0);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_hres, 32'd64);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_vres, 32'd40);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_hoffset, hoff);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_voffset, voff);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_squarew, 32'd16);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_dst_squareh, 32'd16);
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_alpha, alpha);
	endtask

	task automatic run_square(input string name, input logic key_en, input logic check_busy);
		int irq_before;
		int i;
		irq_before = irq_count;
		write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_ctl, {30'd0, key_en, 1'b1});
		for (i = 0; i < mem_words; i++)
			exp_mem[i] = fb_mem[i];
		model_run();
		if (check_busy) begin
			@(posedge sys_clk);
			#2;
			expect_reg({name, " busy"}, tmu_pkg::csr_sel, tmu_pkg::reg_ctl,
				{30'd0, key_en, 1'b1});
			// second start in the middle of the run
			write_csr(tmu_pkg::csr_sel, tmu_pkg::reg_ctl, {30'd0, key_en, 1'b1});
		end
		do begin
			@(posedge sys_clk);
			#2;
		end while (irq_count == irq_before);
		repeat (8) @(posedge sys_clk);
		#2;
		check_value({name, " irq count"}, irq_before + 1, irq_count);
		check_value({name, " irq after last write"}, 32'd1, irq_cycle > last_we_cycle);
		expect_reg({name, " idle"}, tmu_pkg::csr_sel, tmu_pkg::reg_ctl, {30'd0, key_en, 1'b0});
		for (i = 0; i < mem_words; i++)
			check_value($sformatf("%s fb word %0d", name, i), exp_mem[i], fb_mem[i]);
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int          i;
		int          round;
		int          hoff;
		int          voff;
		logic [31:0] data;
		logic [31:0] mask;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		tex_rd_data <= '0;
		fb_rd_data <= '0;
		cycle_cnt = 0;
		irq_count = 0;
		irq_cycle = 0;
		last_we_cycle = 0;
		seed = 32'h37e2_6cbe;
		for (i = 0; i < mem_words; i++) begin
			data = next_rand();
			tex_mem[i] = data[15:0];
			fb_mem[i] <= data[31:16];
		end
		shadow = '{32'd0, 32'd63, 32'd0, 32'd0, 32'd512, 32'h7ff, 32'h7ff, 32'd0,
			32'd640, 32'd480, 32'd0, 32'd0, 32'd16, 32'd16, 32'd63};
		repeat (2) @(posedge sys_clk);
		#2;
		sys_rst = 1'b0;

		for (i = 0; i < 15; i++)
			expect_reg($sformatf("reset reg %0d", i), tmu_pkg::csr_sel, 5'(i), shadow[i]);
		expect_reg("undefined reg 15", tmu_pkg::csr_sel, 5'd15, 32'd0);
		expect_reg("undefined reg 31", tmu_pkg::csr_sel, 5'd31, 32'd0);

		// round 1 goes to another unit and must change nothing
		for (round = 0; round < 2; round++) begin
			for (i = 0; i < 15; i++) begin
				data = next_rand();
				if (i == 0)
					data[0] = 1'b0;
				write_csr(round == 0 ? tmu_pkg::csr_sel : 4'h3, 5'(i), data);
			end
			for (i = 0; i < 15; i++)
				expect_reg($sformatf("readback round %0d reg %0d", round, i),
					tmu_pkg::csr_sel, 5'(i), shadow[i]);
		end
		expect_reg("other select read", 4'h3, tmu_pkg::reg_brightness, 32'd0);

		configure_run(32'd63, 32'd0, 32'h7ff, 32'h7ff, 32'd24, 32'd10, 32'd63);
		run_square("plain copy", 1'b0, 1'b0);

		// key taken from the texel at column 5 of row 3
		data = next_rand();
		configure_run({26'd0, data[5:0]}, {16'd0, tex_mem[12'h123 + 12'd197]},
			32'h7ff, 32'h7ff, 32'd8, 32'd20, 32'd63);
		run_square("chroma key", 1'b1, 1'b0);

		// round 0 clips left and bottom, round 1 clips right and top
		for (round = 0; round < 2; round++) begin
			data = next_rand();
			mask = next_rand();
			hoff = (round == 0) ? -1 - int'(data[8:6]) : 52 + int'(data[8:6]);
			voff = (round == 0) ? 36 - int'(data[11:9]) : -1 - int'(data[11:9]);
			configure_run({26'd0, mask[5:0]}, 32'd0, {21'd0, mask[16:6]},
				{21'd0, mask[27:17]}, 32'(hoff), 32'(voff),
				{26'd0, data[5:0] % 6'd63});
			run_square($sformatf("blend run %0d", round), 1'b0, round == 1);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

/* tmu.f */
+incdir+test
source/tmu_pkg.sv
source/tmu_ctlif.sv
source/tmu_scan.sv
source/tmu_addr.sv
source/tmu_blend.sv
source/tmu_top.sv
test/tb_tmu.sv
